/* hdl/cache_pkg.sv */
// ---------------------------------------------------------------------------
// Shared definitions for the two-way data cache
// Address field widths, word and line sizes
// Request kind and controller state enums
// ---------------------------------------------------------------------------
`default_nettype none

package cache_pkg;

   localparam int TAG_W    = 5;
   localparam int INDEX_W  = 8;
   localparam int OFFSET_W = 3;
   localparam int ADDR_W   = TAG_W + INDEX_W + OFFSET_W;

   localparam int WORD_W         = 16;
   localparam int WORDS_PER_LINE = 4;
   localparam int WSEL_W         = $clog2(WORDS_PER_LINE); // Word select within a line

   typedef enum logic [1:0] {
      REQ_NONE,
      REQ_READ,
      REQ_WRITE,
      REQ_ERR
   } req_t;

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      WB_REQ,
      WB_WAIT,
      FILL_REQ,
      FILL_WAIT,
      FINISH
   } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/cache_if.sv */
// ---------------------------------------------------------------------------
// Controller to cache way interface
// ctrl modport drives the access, way modport returns lookup results
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface cache_if;
   import cache_pkg::*;

   logic                enable;
   logic                comp;     // Compare mode, tag checked
   logic                write;
   logic                valid_in;
   logic [TAG_W-1:0]    tag;
   logic [INDEX_W-1:0]  index;
   logic [OFFSET_W-1:0] offset;
   logic [WORD_W-1:0]   wdata;

   logic                hit;
   logic                dirty;
   logic                valid;
   logic [TAG_W-1:0]    tag_out;
   logic [WORD_W-1:0]   rdata;

   modport ctrl (
      output enable, comp, write, valid_in, tag, index, offset, wdata,
      input  hit, dirty, valid, tag_out, rdata
   );

   modport way (
      input  enable, comp, write, valid_in, tag, index, offset, wdata,
      output hit, dirty, valid, tag_out, rdata
   );

endinterface

`default_nettype wire

/* hdl/cache_way.sv */
// ---------------------------------------------------------------------------
// One way of the cache
// Tag, valid and dirty arrays with line data, tag compare
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cache_way (
   input wire clk,
   input wire rst,
   cache_if.way bus
);
   import cache_pkg::*;

   localparam int SETS = 1 << INDEX_W;

   logic [TAG_W-1:0]  tag_mem [SETS];
   logic [WORD_W-1:0] data_mem [SETS*WORDS_PER_LINE];
   logic [SETS-1:0]   valid_bits;
   logic [SETS-1:0]   dirty_bits;

   logic [INDEX_W+WSEL_W-1:0] waddr;
   logic                      tag_match;
   logic                      entry_hit;
   logic                      lookup_wr;
   logic                      fill_wr;

   // Offset bit 0 is the byte within a word
   assign waddr     = {bus.index, bus.offset[WSEL_W:1]};
   assign tag_match = (tag_mem[bus.index] == bus.tag);
   assign entry_hit = valid_bits[bus.index] & tag_match;

   assign lookup_wr = bus.enable & bus.write & bus.comp & entry_hit;
   assign fill_wr   = bus.enable & bus.write & ~bus.comp;

   assign bus.hit     = entry_hit;
   assign bus.valid   = valid_bits[bus.index];
   assign bus.dirty   = dirty_bits[bus.index];
   assign bus.tag_out = tag_mem[bus.index];
   assign bus.rdata   = data_mem[waddr];

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (fill_wr) begin
         valid_bits[bus.index] <= bus.valid_in;
         dirty_bits[bus.index] <= 1'b0;  // Fresh line from memory
      end else if (lookup_wr) begin
         dirty_bits[bus.index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (lookup_wr || fill_wr) begin
         data_mem[waddr] <= bus.wdata;
      end
      if (fill_wr) begin
         tag_mem[bus.index] <= bus.tag;
      end
   end

endmodule

`default_nettype wire

/* hdl/bank_mem.sv */
// ---------------------------------------------------------------------------
// Four-bank word-interleaved main memory
// Per-bank busy timers, pipelined read return
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bank_mem #(
   parameter int MEM_LATENCY = 2,
   parameter int BANK_BUSY   = 4,
   parameter int MEM_WORDS   = 32768
) (
   input  wire                         clk,
   input  wire                         rst,
   input  wire [cache_pkg::ADDR_W-1:0] mem_addr,
   input  wire [cache_pkg::WORD_W-1:0] mem_wdata,
   input  wire                         mem_wr,
   input  wire                         mem_rd,
   output logic [cache_pkg::WORD_W-1:0] mem_rdata,
   output logic                        mem_rvalid,
   output logic                        mem_stall
);
   import cache_pkg::*;

   localparam int ROWS   = MEM_WORDS / 4;
   localparam int ROW_W  = $clog2(ROWS);
   localparam int BUSY_W = $clog2(BANK_BUSY + 1);

   logic [WORD_W-1:0] banks [4][ROWS];
   logic [BUSY_W-1:0] busy [4];

   logic [1:0]        bank_sel;
   logic [ROW_W-1:0]  row;
   logic              accept;

   logic [MEM_LATENCY-1:0] rv_pipe;
   logic [WORD_W-1:0]      rd_pipe [MEM_LATENCY];

   assign bank_sel  = mem_addr[2:1];  // Consecutive words hit different banks
   assign row       = mem_addr[ROW_W+2:3];
   assign mem_stall = (busy[bank_sel] != '0);
   assign accept    = (mem_rd | mem_wr) & ~mem_stall;

   assign mem_rdata  = rd_pipe[MEM_LATENCY-1];
   assign mem_rvalid = rv_pipe[MEM_LATENCY-1];

   initial begin
      for (int b = 0; b < 4; b++) begin
         for (int r = 0; r < ROWS; r++) begin
            banks[b][r] = '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < 4; b++) begin
            busy[b] <= '0;
         end
         rv_pipe <= '0;
      end else begin
         for (int b = 0; b < 4; b++) begin
            if (accept && (bank_sel == 2'(b))) begin
               busy[b] <= BUSY_W'(BANK_BUSY);
            end else if (busy[b] != '0) begin
               busy[b] <= busy[b] - 1'b1;
            end
         end
         rv_pipe[0] <= accept & mem_rd;
         for (int k = 1; k < MEM_LATENCY; k++) begin
            rv_pipe[k] <= rv_pipe[k-1];
         end
      end
   end

   // Array and return data carry no reset
   always_ff @(posedge clk) begin
      if (accept && mem_wr) begin
         banks[bank_sel][row] <= mem_wdata;
      end
      rd_pipe[0] <= banks[bank_sel][row];
      for (int k = 1; k < MEM_LATENCY; k++) begin
         rd_pipe[k] <= rd_pipe[k-1];
      end
   end

endmodule

`default_nettype wire

/* hdl/line_counter.sv */
// ---------------------------------------------------------------------------
// Word counters for line transfers
// Separate request and response offsets so reads run ahead of returns
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module line_counter (
   input  wire                         clk,
   input  wire                         rst,
   input  wire                         clear,
   input  wire                         step_req,
   input  wire                         step_rsp,
   output logic [cache_pkg::WSEL_W-1:0] req_off,
   output logic [cache_pkg::WSEL_W-1:0] rsp_off,
   output logic                        req_last,
   output logic                        rsp_last
);
   import cache_pkg::*;

   assign req_last = (req_off == WSEL_W'(WORDS_PER_LINE - 1));
   assign rsp_last = (rsp_off == WSEL_W'(WORDS_PER_LINE - 1));

   always_ff @(posedge clk) begin
      if (rst || clear) begin
         req_off <= '0;
         rsp_off <= '0;
      end else begin
         if (step_req) req_off <= req_off + 1'b1;
         if (step_rsp) rsp_off <= rsp_off + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* hdl/cache_ctrl.sv */
// ---------------------------------------------------------------------------
// Cache controller FSM
// Lookup, dirty writeback, pipelined fill and retry of the request
// Victim selection between the two ways
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
   parameter int MEM_LATENCY = 2
) (
   input  wire                          clk,
   input  wire                          rst,
   input  wire  [cache_pkg::ADDR_W-1:0] addr,
   input  wire  [cache_pkg::WORD_W-1:0] data_in,
   input  wire                          rd,
   input  wire                          wr,
   output logic [cache_pkg::WORD_W-1:0] data_out,
   output logic                         done,
   output logic                         stall,
   output logic                         cache_hit,
   output logic                         err,
   cache_if.ctrl                        way0,
   cache_if.ctrl                        way1,
   output logic [cache_pkg::ADDR_W-1:0] mem_addr,
   output logic [cache_pkg::WORD_W-1:0] mem_wdata,
   output logic                         mem_wr,
   output logic                         mem_rd,
   input  wire  [cache_pkg::WORD_W-1:0] mem_rdata,
   input  wire                          mem_rvalid,
   input  wire                          mem_stall,
   output logic                         cnt_clear,
   output logic                         step_req,
   output logic                         step_rsp,
   input  wire  [cache_pkg::WSEL_W-1:0] req_off,
   input  wire  [cache_pkg::WSEL_W-1:0] rsp_off,
   input  wire                          req_last,
   input  wire                          rsp_last
);
   import cache_pkg::*;

   localparam int INFL_W = $clog2(MEM_LATENCY + 1);

   ctrl_state_t state;
   req_t        req_kind;

   logic [TAG_W-1:0]    req_tag;
   logic [INDEX_W-1:0]  req_index;
   logic [OFFSET_W-1:0] req_offset;
   logic [WORD_W-1:0]   req_data;
   logic [TAG_W-1:0]    vic_tag;
   logic [WORD_W-1:0]   wb_data;
   logic                victim;   // Toggles per request
   logic                sel_way;
   logic [INFL_W-1:0]   inflight;

   logic                pick_way;
   logic                pick_dirty;
   logic                lookup_hit;
   logic [WORD_W-1:0]   sel_rdata;
   logic                can_issue;
   logic                wb_accept;
   logic                rd_accept;
   logic                fill_rsp;

   logic [1:0]          way_en;
   logic                way_comp;
   logic                way_write;
   logic                way_vin;
   logic [OFFSET_W-1:0] way_off;
   logic [WORD_W-1:0]   way_wdata;

   // Invalid way first, way 0 before way 1
   assign pick_way   = way0.valid ? (way1.valid ? victim : 1'b1) : 1'b0;
   assign pick_dirty = pick_way ? (way1.valid & way1.dirty) : (way0.valid & way0.dirty);
   assign lookup_hit = way0.hit | way1.hit;
   assign sel_rdata  = sel_way ? way1.rdata : way0.rdata;

   // Never more reads in flight than the return pipeline holds
   assign can_issue = (inflight < INFL_W'(MEM_LATENCY)) || mem_rvalid;

   assign stall     = (state != IDLE);
   assign mem_wr    = (state == WB_WAIT);
   assign mem_rd    = (state == FILL_REQ) && can_issue;
   assign mem_wdata = wb_data;
   assign mem_addr  = (state == WB_WAIT) ? {vic_tag, req_index, req_off, 1'b0}
                                         : {req_tag, req_index, req_off, 1'b0};

   assign wb_accept = mem_wr & ~mem_stall;
   assign rd_accept = mem_rd & ~mem_stall;
   assign fill_rsp  = mem_rvalid && ((state == FILL_REQ) || (state == FILL_WAIT));

   assign cnt_clear = (state == LOOKUP) || (wb_accept && req_last);
   assign step_req  = wb_accept | rd_accept;
   assign step_rsp  = fill_rsp;

   always_comb begin
      way_en    = 2'b00;
      way_comp  = 1'b0;
      way_write = 1'b0;
      way_vin   = 1'b0;
      way_off   = req_offset;
      way_wdata = req_data;
      case (state)
         LOOKUP, FINISH: begin
            if (req_kind != REQ_ERR) begin
               way_en    = 2'b11;  // Only the matching way commits
               way_comp  = 1'b1;
               way_write = (req_kind == REQ_WRITE);
            end
         end
         WB_REQ: begin
            way_en[sel_way] = 1'b1;
            way_off         = {req_off, 1'b0};
         end
         FILL_REQ, FILL_WAIT: begin
            if (mem_rvalid) begin
               way_en[sel_way] = 1'b1;
               way_write       = 1'b1;
               way_vin         = 1'b1;
               way_off         = {rsp_off, 1'b0};
               way_wdata       = mem_rdata;
            end
         end
         default: ;
      endcase
   end

   assign way0.enable   = way_en[0];
   assign way1.enable   = way_en[1];
   assign way0.comp     = way_comp;
   assign way1.comp     = way_comp;
   assign way0.write    = way_write;
   assign way1.write    = way_write;
   assign way0.valid_in = way_vin;
   assign way1.valid_in = way_vin;
   assign way0.tag      = req_tag;
   assign way1.tag      = req_tag;
   assign way0.index    = req_index;
   assign way1.index    = req_index;
   assign way0.offset   = way_off;
   assign way1.offset   = way_off;
   assign way0.wdata    = way_wdata;
   assign way1.wdata    = way_wdata;

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= IDLE;
         req_kind  <= REQ_NONE;
         victim    <= 1'b0;
         inflight  <= '0;
         done      <= 1'b0;
         cache_hit <= 1'b0;
         err       <= 1'b0;
      end else begin
         done     <= 1'b0;
         inflight <= inflight + INFL_W'(rd_accept) - INFL_W'(mem_rvalid);
         case (state)
            IDLE: begin
               if (rd || wr) begin
                  {req_tag, req_index, req_offset} <= addr;
                  req_data <= data_in;
                  victim   <= ~victim;
                  if ((rd && wr) || addr[0]) req_kind <= REQ_ERR;
                  else if (rd)               req_kind <= REQ_READ;
                  else                       req_kind <= REQ_WRITE;
                  state <= LOOKUP;
               end
            end
            LOOKUP: begin
               if (req_kind == REQ_ERR) begin
                  done      <= 1'b1;
                  err       <= 1'b1;
                  cache_hit <= 1'b0;
                  state     <= IDLE;
               end else if (lookup_hit) begin
                  done      <= 1'b1;
                  err       <= 1'b0;
                  cache_hit <= 1'b1;
                  if (req_kind == REQ_READ) data_out <= way0.hit ? way0.rdata : way1.rdata;
                  state <= IDLE;
               end else begin
                  sel_way <= pick_way;
                  vic_tag <= pick_way ? way1.tag_out : way0.tag_out;
                  state   <= pick_dirty ? WB_REQ : FILL_REQ;
               end
            end
            WB_REQ: begin
               wb_data <= sel_rdata;
               state   <= WB_WAIT;
            end
            WB_WAIT: begin
               if (wb_accept) state <= req_last ? FILL_REQ : WB_REQ;
            end
            FILL_REQ: begin
               if (rd_accept && req_last) state <= FILL_WAIT;
            end
            FILL_WAIT: begin
               if (fill_rsp && rsp_last) state <= FINISH;
            end
            FINISH: begin
               done      <= 1'b1;  // Retried access hits now
               err       <= 1'b0;
               cache_hit <= 1'b0;
               if (req_kind == REQ_READ) data_out <= sel_rdata;
               state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/mem_system.sv */
// ---------------------------------------------------------------------------
// Memory system top
// Two cache ways, controller, line counter and banked main memory
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_system #(
   parameter int MEM_LATENCY = 2,
   parameter int BANK_BUSY   = 4,
   parameter int MEM_WORDS   = 32768
) (
   input  wire                          clk,
   input  wire                          rst,
   input  wire  [cache_pkg::ADDR_W-1:0] addr,
   input  wire  [cache_pkg::WORD_W-1:0] data_in,
   input  wire                          rd,
   input  wire                          wr,
   output logic [cache_pkg::WORD_W-1:0] data_out,
   output logic                         done,
   output logic                         stall,
   output logic                         cache_hit,
   output logic                         err
);
   import cache_pkg::*;

   logic [ADDR_W-1:0] mem_addr;
   logic [WORD_W-1:0] mem_wdata;
   logic [WORD_W-1:0] mem_rdata;
   logic              mem_wr;
   logic              mem_rd;
   logic              mem_rvalid;
   logic              mem_stall;

   logic              cnt_clear;
   logic              step_req;
   logic              step_rsp;
   logic [WSEL_W-1:0] req_off;
   logic [WSEL_W-1:0] rsp_off;
   logic              req_last;
   logic              rsp_last;

   cache_if way0_if ();
   cache_if way1_if ();

   cache_way u_way0 (.clk(clk), .rst(rst), .bus(way0_if.way));
   cache_way u_way1 (.clk(clk), .rst(rst), .bus(way1_if.way));

   bank_mem #(
      .MEM_LATENCY (MEM_LATENCY),
      .BANK_BUSY   (BANK_BUSY),
      .MEM_WORDS   (MEM_WORDS)
   ) u_bank_mem (
      .clk        (clk),
      .rst        (rst),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_wr     (mem_wr),
      .mem_rd     (mem_rd),
      .mem_rdata  (mem_rdata),
      .mem_rvalid (mem_rvalid),
      .mem_stall  (mem_stall)
   );

   line_counter u_line_counter (
      .clk      (clk),
      .rst      (rst),
      .clear    (cnt_clear),
      .step_req (step_req),
      .step_rsp (step_rsp),
      .req_off  (req_off),
      .rsp_off  (rsp_off),
      .req_last (req_last),
      .rsp_last (rsp_last)
   );

   cache_ctrl #(
      .MEM_LATENCY (MEM_LATENCY)
   ) u_cache_ctrl (
      .clk        (clk),
      .rst        (rst),
      .addr       (addr),
      .data_in    (data_in),
      .rd         (rd),
      .wr         (wr),
      .data_out   (data_out),
      .done       (done),
      .stall      (stall),
      .cache_hit  (cache_hit),
      .err        (err),
      .way0       (way0_if.ctrl),
      .way1       (way1_if.ctrl),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_wr     (mem_wr),
      .mem_rd     (mem_rd),
      .mem_rdata  (mem_rdata),
      .mem_rvalid (mem_rvalid),
      .mem_stall  (mem_stall),
      .cnt_clear  (cnt_clear),
      .step_req   (step_req),
      .step_rsp   (step_rsp),
      .req_off    (req_off),
      .rsp_off    (rsp_off),
      .req_last   (req_last),
      .rsp_last   (rsp_last)
   );

endmodule

`default_nettype wire

/* testbench/tb_checks.svh */
// ---------------------------------------------------------------------------
// Testbench checks for the cache memory system
// Shadow memory, reference functions and typed compare tasks
// ---------------------------------------------------------------------------
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Word-addressed view of what main memory should hold
logic [WORD_W-1:0] shadow [1 << (ADDR_W-1)];

function automatic logic [WORD_W-1:0] expected_read(input logic [ADDR_W-1:0] a);
   return shadow[a[ADDR_W-1:1]];
endfunction

// Misaligned or rd with wr is an error, otherwise the kind driven
function automatic req_t expected_kind(input logic do_rd, input logic do_wr,
                                       input logic [ADDR_W-1:0] a);
   if ((do_rd && do_wr) || a[0])
      return REQ_ERR;
   else if (do_rd)
      return REQ_READ;
   else if (do_wr)
      return REQ_WRITE;
   else
      return REQ_NONE;
endfunction

task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                          input logic [WORD_W-1:0] act);
   if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "data word mismatch");
   end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
   if (act !== exp) begin
      $display("FAILED %s: expected %0b, actual %0b", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "flag mismatch");
   end
endtask

task automatic check_req(input string name, input req_t exp, input req_t act);
   if (act !== exp) begin
      $display("FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
      $display("TESTS FAILED");
      $fatal(1, "request kind mismatch");
   end
endtask

`endif

/* testbench/tb_mem_system.sv */
// ---------------------------------------------------------------------------
// Testbench for the two-way cache memory system
// Clock and reset, directed and random request sequences
// Compare process at each done, cycle limit watchdog
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_mem_system;
   import cache_pkg::*;

   localparam int NUM_REQS    = 4 + 8 + 6 + 300 + 5 + 6;  // Requests over all tests
   localparam int CYCLE_LIMIT = NUM_REQS * 40 + 100;

   logic              clk;
   logic              rst;
   logic [ADDR_W-1:0] addr;
   logic [WORD_W-1:0] data_in;
   logic              rd;
   logic              wr;
   logic [WORD_W-1:0] data_out;
   logic              done;
   logic              stall;
   logic              cache_hit;
   logic              err;

   // Outstanding request as seen by the compare process
   string             pend_name;
   req_t              pend_kind;
   logic [ADDR_W-1:0] pend_addr;
   logic [WORD_W-1:0] pend_data;
   logic              pend_rd;
   logic              pend_chk_hit;
   logic              pend_exp_hit;
   logic              pend_active;
   logic              pend_accepted;  // Sampled by the DUT, stall expected until done
   int                resp_count;
   int                cycle_count;
   int                seed;

   `include "tb_checks.svh"

   mem_system #(
      .MEM_LATENCY (2),
      .BANK_BUSY   (4),
      .MEM_WORDS   (32768)
   ) u_mem_system (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                   input logic [INDEX_W-1:0] index,
                                                   input logic [WSEL_W-1:0] word);
      return {tag, index, word, 1'b0};
   endfunction

   task automatic apply_reset();
      rst = 1'b1;
      repeat (8) @(posedge clk);
      #5;
      rst = 1'b0;
   endtask

   // Drive one request, hold it until accepted, wait for its done
   task automatic issue_req(input string name, input logic do_rd, input logic do_wr,
                            input logic [ADDR_W-1:0] a, input logic [WORD_W-1:0] d,
                            input logic chk_hit, input logic exp_hit);
      int start;
      start        = resp_count;
      pend_name    = name;
      pend_kind    = expected_kind(do_rd, do_wr, a);
      pend_addr    = a;
      pend_data    = d;
      pend_rd      = do_rd;
      pend_chk_hit = chk_hit;
      pend_exp_hit = exp_hit;
      pend_active  = 1'b1;
      rd      = do_rd;
      wr      = do_wr;
      addr    = a;
      data_in = d;
      while (stall) begin
         @(posedge clk);
         #5;
      end
      @(posedge clk);
      #5;
      rd = 1'b0;
      wr = 1'b0;
      pend_accepted = 1'b1;
      wait (resp_count != start);
      pend_active   = 1'b0;
      pend_accepted = 1'b0;
      @(posedge clk);
      #5;
   endtask

   always @(negedge clk) begin
      req_t seen;
      if (!rst && pend_accepted && !done)
         check_flag($sformatf("%s stall", pend_name), 1'b1, stall);
      if (!rst && done) begin
         if (!pend_active) begin
            $display("done pulse seen with no request outstanding");
            $display("TESTS FAILED");
            $fatal(1, "unexpected done");
         end else begin
            seen = err ? REQ_ERR : (pend_rd ? REQ_READ : REQ_WRITE);
            check_req(pend_name, pend_kind, seen);
            if (pend_kind == REQ_READ)
               check_word(pend_name, expected_read(pend_addr), data_out);
            if (pend_chk_hit)
               check_flag(pend_name, pend_exp_hit, cache_hit);
            if (pend_kind == REQ_WRITE)
               shadow[pend_addr[ADDR_W-1:1]] = pend_data;
            resp_count = resp_count + 1;
         end
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_count = cycle_count + 1;
      end
      $display("no done within limit of %0d cycles", CYCLE_LIMIT);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
   end

   initial begin
      logic [31:0]       r;
      logic [ADDR_W-1:0] a;
      rst           = 1'b1;
      rd            = 1'b0;
      wr            = 1'b0;
      addr          = '0;
      data_in       = '0;
      pend_active   = 1'b0;
      pend_accepted = 1'b0;
      resp_count    = 0;
      seed          = 71228;
      for (int i = 0; i < (1 << (ADDR_W-1)); i++) begin
         shadow[i] = '0;
      end
      apply_reset();

      // Cold reads, all misses
      issue_req("cold read 0", 1'b1, 1'b0, make_addr(5'd0, 8'd0, 2'd0), '0, 1'b1, 1'b0);
      issue_req("cold read 1", 1'b1, 1'b0, make_addr(5'd1, 8'd5, 2'd1), '0, 1'b1, 1'b0);
      issue_req("cold read 2", 1'b1, 1'b0, make_addr(5'd7, 8'd9, 2'd2), '0, 1'b1, 1'b0);
      issue_req("cold read 3", 1'b1, 1'b0, make_addr(5'd31, 8'd255, 2'd3), '0, 1'b1, 1'b0);

      for (int i = 0; i < 4; i++) begin
         a = make_addr(5'd2, 8'(10 + i), 2'(i));
         issue_req($sformatf("hit write %0d", i), 1'b0, 1'b1, a, 16'(16'h1000 + i * 16'h0111),
                   1'b0, 1'b0);
         issue_req($sformatf("hit read %0d", i), 1'b1, 1'b0, a, '0, 1'b1, 1'b1);
      end

      // Three tags on one index force dirty evictions
      for (int t = 1; t <= 3; t++) begin
         issue_req($sformatf("evict write tag %0d", t), 1'b0, 1'b1,
                   make_addr(5'(t), 8'd100, 2'd1), 16'(16'hA100 + t), 1'b0, 1'b0);
      end
      for (int t = 1; t <= 3; t++) begin
         issue_req($sformatf("evict read tag %0d", t), 1'b1, 1'b0,
                   make_addr(5'(t), 8'd100, 2'd1), '0, 1'b0, 1'b0);
      end

      for (int i = 0; i < 300; i++) begin
         r = $random(seed);
         a = make_addr({3'b000, r[1:0]}, {2'b00, r[7:2]}, r[9:8]);
         if (r[10])
            issue_req($sformatf("random read %0d", i), 1'b1, 1'b0, a, '0, 1'b0, 1'b0);
         else
            issue_req($sformatf("random write %0d", i), 1'b0, 1'b1, a, r[31:16], 1'b0, 1'b0);
      end

      // Error requests leave the shadow untouched
      issue_req("misaligned read", 1'b1, 1'b0, make_addr(5'd1, 8'd5, 2'd0) | 16'h1, '0,
                1'b1, 1'b0);
      issue_req("misaligned write", 1'b0, 1'b1, make_addr(5'd2, 8'd10, 2'd0) | 16'h1,
                16'hDEAD, 1'b1, 1'b0);
      issue_req("rd with wr", 1'b1, 1'b1, make_addr(5'd2, 8'd11, 2'd1), 16'hBEEF, 1'b1, 1'b0);
      issue_req("read after misaligned", 1'b1, 1'b0, make_addr(5'd2, 8'd10, 2'd0), '0,
                1'b0, 1'b0);
      issue_req("read after rd with wr", 1'b1, 1'b0, make_addr(5'd2, 8'd11, 2'd1), '0,
                1'b0, 1'b0);

      // Two back to back misses on a full set evict both ways
      a = make_addr(5'd20, 8'd200, 2'd1);
      issue_req("reset write", 1'b0, 1'b1, a, 16'h5A5A, 1'b0, 1'b0);
      issue_req("reset evict 0", 1'b1, 1'b0, make_addr(5'd21, 8'd200, 2'd0), '0, 1'b0, 1'b0);
      issue_req("reset evict 1", 1'b1, 1'b0, make_addr(5'd22, 8'd200, 2'd0), '0, 1'b0, 1'b0);
      issue_req("reset evict 2", 1'b1, 1'b0, make_addr(5'd23, 8'd200, 2'd0), '0, 1'b0, 1'b0);
      apply_reset();
      issue_req("read after reset", 1'b1, 1'b0, a, '0, 1'b1, 1'b0);
      issue_req("reread after reset", 1'b1, 1'b0, a, '0, 1'b1, 1'b1);

      if (resp_count != NUM_REQS) begin
         $display("%0d requests completed where %0d were issued", resp_count, NUM_REQS);
         $display("TESTS FAILED");
         $fatal(1, "request count mismatch");
      end else begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* sources.f */
+incdir+testbench
hdl/cache_pkg.sv
hdl/cache_if.sv
hdl/cache_way.sv
hdl/bank_mem.sv
hdl/line_counter.sv
hdl/cache_ctrl.sv
hdl/mem_system.sv
testbench/tb_mem_system.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_mem_system \
		-o tb_mem_system
	./obj_dir/tb_mem_system

clean:
	rm -rf obj_dir
